//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := tb_id_stage
FLIST     := compile.f
SIM       := obj_dir/V$(TOP)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST)
	@out=$$(./$(SIM)); echo "$$out"; \
	echo "$$out" | grep -q '^=== PASS ===$$'

clean:
	rm -rf obj_dir

//--- branch_resolve.sv
`timescale 1ns/100ps

module branch_resolve (
	input  mips_id_pkg::decode_t dec_i,
	input  mips_id_pkg::word_t   pc_i,
	input  mips_id_pkg::word_t   raw1_i,
	input  mips_id_pkg::word_t   raw2_i,
	input  mips_id_pkg::word_t   ex_res_i,   // ALU result still in EX
	input  logic                 ex_as1_i,
	input  logic                 ex_as2_i,
	output logic                 branch_en_o,
	output mips_id_pkg::word_t   branch_pc_o,
	output logic                 is_branch_o
);
	import mips_id_pkg::*;

	word_t opr1;
	word_t opr2;
	word_t pc_plus4;
	word_t b_target;
	word_t j_target;
	logic  lz;
	logic  zero;
	logic  eq;
	logic  is_cond;

	assign opr1 = ex_as1_i ? ex_res_i : raw1_i;
	assign opr2 = ex_as2_i ? ex_res_i : raw2_i;

	assign lz   = opr1[31];
	assign zero = opr1 == '0;
	assign eq   = opr1 == opr2;

	assign pc_plus4 = pc_i + 32'd4;
	assign b_target = pc_plus4 + {{14{dec_i.imm[15]}}, dec_i.imm, 2'b00};
	assign j_target = {pc_plus4[31:28], dec_i.j_index, 2'b00};   // 256MB region

	assign is_cond = dec_i.is_beq | dec_i.is_bne | dec_i.is_bgez | dec_i.is_bgtz
		| dec_i.is_blez | dec_i.is_bltz;

	assign branch_en_o = (dec_i.is_beq & eq) | (dec_i.is_bne & ~eq)
		| (dec_i.is_bgez & ~lz) | (dec_i.is_bgtz & ~(lz | zero))
		| (dec_i.is_blez & (lz | zero)) | (dec_i.is_bltz & lz)
		| dec_i.is_jump_imm | dec_i.is_jump_reg;

	assign branch_pc_o = is_cond           ? b_target :
	                     dec_i.is_jump_imm ? j_target : opr1;

	// instructions whose target or decision depends on bypassed data
	assign is_branch_o = is_cond | dec_i.is_jump_reg;

endmodule

//--- compile.f
mips_id_pkg.sv
inst_decode.sv
operand_select.sv
branch_resolve.sv
id_ex_reg.sv
id_stage.sv
id_stage_props.sv
tb_id_stage.sv

//--- id_ex_reg.sv
`timescale 1ns/100ps

module id_ex_reg (
	input  logic                clk,
	input  logic                rst_n_i,
	input  logic                stall_i,    // hold, wins over flush
	input  logic                flush_i,
	input  mips_id_pkg::id_ex_t next_i,
	output mips_id_pkg::id_ex_t q_o
);

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			q_o <= '0;
		end else if (!stall_i) begin
			if (flush_i) begin
				q_o <= '0;   // bubble
			end else begin
				q_o <= next_i;
			end
		end
	end

endmodule

//--- id_stage.sv
`timescale 1ns/100ps

module id_stage (
	input  logic                   clk,
	input  logic                   rst_n_i,
	input  logic                   id_stall_i,
	input  logic                   id_flush_i,
	input  mips_id_pkg::word_t     id_pc_i,
	input  mips_id_pkg::word_t     id_inst_i,
	input  logic                   id_exc_i,
	input  mips_id_pkg::word_t     id_reg1data_i,
	input  mips_id_pkg::word_t     id_reg2data_i,
	input  mips_id_pkg::word_t     raw_data1_i,    // regfile data for branch compare
	input  mips_id_pkg::word_t     raw_data2_i,
	input  mips_id_pkg::word_t     id_res_from_ex_i,
	input  logic                   id_ex_res_as1_i,
	input  logic                   id_ex_res_as2_i,
	output logic                   id_ren1_o,
	output logic                   id_ren2_o,
	output mips_id_pkg::reg_addr_t id_reg1addr_o,
	output mips_id_pkg::reg_addr_t id_reg2addr_o,
	output logic                   id_branch_en_o,
	output mips_id_pkg::word_t     id_branch_pc_o,
	output logic                   id_is_branch_o,
	output mips_id_pkg::id_ex_t    id_ex_o
);
	import mips_id_pkg::*;

	decode_t dec;
	id_ex_t  id_ex_next;

	inst_decode i_decode (
		.inst_i (id_inst_i),
		.dec_o  (dec)
	);

	operand_select i_opsel (
		.dec_i      (dec),
		.pc_i       (id_pc_i),
		.reg1data_i (id_reg1data_i),
		.reg2data_i (id_reg2data_i),
		.exc_i      (id_exc_i),
		.next_o     (id_ex_next),
		.ren1_o     (id_ren1_o),
		.ren2_o     (id_ren2_o),
		.reg1addr_o (id_reg1addr_o),
		.reg2addr_o (id_reg2addr_o)
	);

	branch_resolve i_branch (
		.dec_i       (dec),
		.pc_i        (id_pc_i),
		.raw1_i      (raw_data1_i),
		.raw2_i      (raw_data2_i),
		.ex_res_i    (id_res_from_ex_i),
		.ex_as1_i    (id_ex_res_as1_i),
		.ex_as2_i    (id_ex_res_as2_i),
		.branch_en_o (id_branch_en_o),
		.branch_pc_o (id_branch_pc_o),
		.is_branch_o (id_is_branch_o)
	);

	id_ex_reg i_id_ex (
		.clk     (clk),
		.rst_n_i (rst_n_i),
		.stall_i (id_stall_i),
		.flush_i (id_flush_i),
		.next_i  (id_ex_next),
		.q_o     (id_ex_o)
	);

endmodule

//--- id_stage_props.sv
`timescale 1ns/100ps

module id_stage_props (
	input logic                clk,
	input logic                rst_n_i,
	input logic                id_stall_i,
	input logic                id_flush_i,
	input mips_id_pkg::id_ex_t id_ex_o
);

	a_reset_zero: assert property (@(posedge clk) !rst_n_i |=> id_ex_o == '0)
		else $error("id_ex_o not cleared by reset");

	// stall wins over flush
	a_stall_hold: assert property (@(posedge clk) rst_n_i && id_stall_i |=> $stable(id_ex_o))
		else $error("id_ex_o changed during stall");

	a_flush_zero: assert property (@(posedge clk)
		rst_n_i && !id_stall_i && id_flush_i |=> id_ex_o == '0)
		else $error("id_ex_o not zero after flush");

endmodule

bind id_stage id_stage_props i_props (.*);

//--- inst_decode.sv
`timescale 1ns/100ps

module inst_decode (
	input  mips_id_pkg::word_t   inst_i,
	output mips_id_pkg::decode_t dec_o
);
	import mips_id_pkg::*;

	logic [5:0] opcode;
	logic [5:0] funct;
	reg_addr_t  rs, rt, rd, sa;
	logic       r_alu;   // SPECIAL with sa == 0
	logic       inst_add, inst_addu, inst_sub, inst_subu, inst_slt, inst_sltu;
	logic       inst_and, inst_or, inst_xor, inst_nor;
	logic       inst_sll, inst_srl, inst_sra, inst_sllv, inst_srlv, inst_srav;
	logic       inst_addi, inst_addiu, inst_slti, inst_sltiu;
	logic       inst_andi, inst_ori, inst_xori, inst_lui;
	logic       inst_lb, inst_lbu, inst_lh, inst_lhu, inst_lw, inst_sb, inst_sh, inst_sw;
	logic       inst_beq, inst_bne, inst_bgez, inst_bgtz, inst_blez, inst_bltz;
	logic       inst_bgezal, inst_bltzal, inst_j, inst_jal, inst_jr, inst_jalr;
	logic       inst_syscall, inst_break;
	logic       is_load, is_store, is_link, cond_nolink, inst_valid;

	assign opcode = inst_i[31:26];
	assign rs     = inst_i[25:21];
	assign rt     = inst_i[20:16];
	assign rd     = inst_i[15:11];
	assign sa     = inst_i[10:6];
	assign funct  = inst_i[5:0];

	assign r_alu       = (opcode == OP_SPECIAL) && (sa == '0);
	assign inst_add    = r_alu && (funct == FN_ADD);
	assign inst_addu   = r_alu && (funct == FN_ADDU);
	assign inst_sub    = r_alu && (funct == FN_SUB);
	assign inst_subu   = r_alu && (funct == FN_SUBU);
	assign inst_slt    = r_alu && (funct == FN_SLT);
	assign inst_sltu   = r_alu && (funct == FN_SLTU);
	assign inst_and    = r_alu && (funct == FN_AND);
	assign inst_or     = r_alu && (funct == FN_OR);
	assign inst_xor    = r_alu && (funct == FN_XOR);
	assign inst_nor    = r_alu && (funct == FN_NOR);
	assign inst_sllv   = r_alu && (funct == FN_SLLV);
	assign inst_srlv   = r_alu && (funct == FN_SRLV);
	assign inst_srav   = r_alu && (funct == FN_SRAV);
	// fixed shifts carry sa, so rs must be zero instead
	assign inst_sll    = (opcode == OP_SPECIAL) && (funct == FN_SLL) && (rs == '0);
	assign inst_srl    = (opcode == OP_SPECIAL) && (funct == FN_SRL) && (rs == '0);
	assign inst_sra    = (opcode == OP_SPECIAL) && (funct == FN_SRA) && (rs == '0);
	assign inst_jr     = r_alu && (funct == FN_JR) && (rt == '0) && (rd == '0);
	assign inst_jalr   = r_alu && (funct == FN_JALR) && (rt == '0);
	assign inst_syscall = (opcode == OP_SPECIAL) && (funct == FN_SYSCALL);
	assign inst_break  = (opcode == OP_SPECIAL) && (funct == FN_BREAK);

	assign inst_addi   = opcode == OP_ADDI;
	assign inst_addiu  = opcode == OP_ADDIU;
	assign inst_slti   = opcode == OP_SLTI;
	assign inst_sltiu  = opcode == OP_SLTIU;
	assign inst_andi   = opcode == OP_ANDI;
	assign inst_ori    = opcode == OP_ORI;
	assign inst_xori   = opcode == OP_XORI;
	assign inst_lui    = (opcode == OP_LUI) && (rs == '0);
	assign inst_lb     = opcode == OP_LB;
	assign inst_lbu    = opcode == OP_LBU;
	assign inst_lh     = opcode == OP_LH;
	assign inst_lhu    = opcode == OP_LHU;
	assign inst_lw     = opcode == OP_LW;
	assign inst_sb     = opcode == OP_SB;
	assign inst_sh     = opcode == OP_SH;
	assign inst_sw     = opcode == OP_SW;

	assign inst_beq    = opcode == OP_BEQ;
	assign inst_bne    = opcode == OP_BNE;
	assign inst_bgtz   = (opcode == OP_BGTZ) && (rt == '0);
	assign inst_blez   = (opcode == OP_BLEZ) && (rt == '0);
	assign inst_bltz   = (opcode == OP_REGIMM) && (rt == RT_BLTZ);
	assign inst_bgez   = (opcode == OP_REGIMM) && (rt == RT_BGEZ);
	assign inst_bltzal = (opcode == OP_REGIMM) && (rt == RT_BLTZAL);
	assign inst_bgezal = (opcode == OP_REGIMM) && (rt == RT_BGEZAL);
	assign inst_j      = opcode == OP_J;
	assign inst_jal    = opcode == OP_JAL;

	assign is_load     = inst_lb | inst_lbu | inst_lh | inst_lhu | inst_lw;
	assign is_store    = inst_sb | inst_sh | inst_sw;
	assign is_link     = inst_jal | inst_jalr | inst_bgezal | inst_bltzal;
	assign cond_nolink = inst_beq | inst_bne | inst_bgez | inst_bgtz | inst_blez | inst_bltz;
	assign inst_valid  = inst_add | inst_addu | inst_sub | inst_subu | inst_slt | inst_sltu
		| inst_and | inst_or | inst_xor | inst_nor | inst_sll | inst_srl | inst_sra
		| inst_sllv | inst_srlv | inst_srav | inst_addi | inst_addiu | inst_slti
		| inst_sltiu | inst_andi | inst_ori | inst_xori | inst_lui | is_load | is_store
		| cond_nolink | is_link | inst_j | inst_jr | inst_syscall | inst_break;

	always_comb begin
		dec_o.alu_op[0]  = inst_add | inst_addu | inst_addi | inst_addiu
			| is_load | is_store | is_link;       // address calc and pc + 8
		dec_o.alu_op[1]  = inst_sub | inst_subu;
		dec_o.alu_op[2]  = inst_slt | inst_slti;
		dec_o.alu_op[3]  = inst_sltu | inst_sltiu;
		dec_o.alu_op[4]  = inst_and | inst_andi;
		dec_o.alu_op[5]  = inst_nor;
		dec_o.alu_op[6]  = inst_or | inst_ori;
		dec_o.alu_op[7]  = inst_xor | inst_xori;
		dec_o.alu_op[8]  = inst_sll | inst_sllv;
		dec_o.alu_op[9]  = inst_srl | inst_srlv;
		dec_o.alu_op[10] = inst_sra | inst_srav;
		dec_o.alu_op[11] = inst_lui;
		dec_o.mem_op     = {inst_sw, inst_sh, inst_sb, inst_lw, inst_lhu, inst_lh, inst_lbu, inst_lb};

		dec_o.src1_is_sa    = inst_sll | inst_srl | inst_sra;
		dec_o.src1_is_pc    = is_link;
		dec_o.src2_is_imm_s = inst_addi | inst_addiu | inst_slti | inst_sltiu | is_load | is_store;
		dec_o.src2_is_imm_u = inst_andi | inst_ori | inst_xori;
		dec_o.src2_is_8     = is_link;
		dec_o.waddr_is_31   = is_link;
		dec_o.waddr_is_rt   = inst_addi | inst_addiu | inst_slti | inst_sltiu | inst_andi
			| inst_ori | inst_xori | inst_lui | is_load;
		dec_o.wren = ~(is_store | cond_nolink | inst_j | inst_jr | inst_syscall | inst_break
			| ~inst_valid);

		dec_o.ren1 = inst_add | inst_addu | inst_sub | inst_subu | inst_slt | inst_sltu
			| inst_and | inst_or | inst_xor | inst_nor | inst_sllv | inst_srlv | inst_srav
			| inst_addi | inst_addiu | inst_slti | inst_sltiu | inst_andi | inst_ori | inst_xori
			| is_load | is_store | cond_nolink | inst_bgezal | inst_bltzal | inst_jr | inst_jalr;
		dec_o.ren2 = inst_add | inst_addu | inst_sub | inst_subu | inst_slt | inst_sltu
			| inst_and | inst_or | inst_xor | inst_nor | inst_sll | inst_srl | inst_sra
			| inst_sllv | inst_srlv | inst_srav | inst_beq | inst_bne | is_store;

		dec_o.is_beq      = inst_beq;
		dec_o.is_bne      = inst_bne;
		dec_o.is_bgez     = inst_bgez | inst_bgezal;
		dec_o.is_bgtz     = inst_bgtz;
		dec_o.is_blez     = inst_blez;
		dec_o.is_bltz     = inst_bltz | inst_bltzal;
		dec_o.is_jump_imm = inst_j | inst_jal;
		dec_o.is_jump_reg = inst_jr | inst_jalr;
		dec_o.is_syscall  = inst_syscall;
		dec_o.is_break    = inst_break;
		dec_o.is_reserved = ~inst_valid;
		dec_o.is_ov       = inst_add | inst_addi | inst_sub;   // signed overflow traps

		dec_o.rs      = rs;
		dec_o.rt      = rt;
		dec_o.rd      = rd;
		dec_o.sa      = sa;
		dec_o.imm     = inst_i[15:0];
		dec_o.j_index = inst_i[25:0];
	end

endmodule

//--- mips_id_pkg.sv
package mips_id_pkg;

	typedef logic [31:0] word_t;     // data, pc or instruction word
	typedef logic [4:0]  reg_addr_t;
	typedef logic [11:0] alu_op_t;   // one-hot, bit 0 add .. bit 11 lui
	typedef logic [7:0]  mem_op_t;   // one-hot, bit 0 lb .. bit 7 sw
	typedef logic [3:0]  exc_t;      // {reserved, break, syscall, fetch}

	// major opcodes
	localparam logic [5:0] OP_SPECIAL = 6'h00;
	localparam logic [5:0] OP_REGIMM  = 6'h01;
	localparam logic [5:0] OP_J       = 6'h02;
	localparam logic [5:0] OP_JAL     = 6'h03;
	localparam logic [5:0] OP_BEQ     = 6'h04;
	localparam logic [5:0] OP_BNE     = 6'h05;
	localparam logic [5:0] OP_BLEZ    = 6'h06;
	localparam logic [5:0] OP_BGTZ    = 6'h07;
	localparam logic [5:0] OP_ADDI    = 6'h08;
	localparam logic [5:0] OP_ADDIU   = 6'h09;
	localparam logic [5:0] OP_SLTI    = 6'h0a;
	localparam logic [5:0] OP_SLTIU   = 6'h0b;
	localparam logic [5:0] OP_ANDI    = 6'h0c;
	localparam logic [5:0] OP_ORI     = 6'h0d;
	localparam logic [5:0] OP_XORI    = 6'h0e;
	localparam logic [5:0] OP_LUI     = 6'h0f;
	localparam logic [5:0] OP_LB      = 6'h20;
	localparam logic [5:0] OP_LH      = 6'h21;
	localparam logic [5:0] OP_LW      = 6'h23;
	localparam logic [5:0] OP_LBU     = 6'h24;
	localparam logic [5:0] OP_LHU     = 6'h25;
	localparam logic [5:0] OP_SB      = 6'h28;
	localparam logic [5:0] OP_SH      = 6'h29;
	localparam logic [5:0] OP_SW      = 6'h2b;

	// SPECIAL function field
	localparam logic [5:0] FN_SLL     = 6'h00;
	localparam logic [5:0] FN_SRL     = 6'h02;
	localparam logic [5:0] FN_SRA     = 6'h03;
	localparam logic [5:0] FN_SLLV    = 6'h04;
	localparam logic [5:0] FN_SRLV    = 6'h06;
	localparam logic [5:0] FN_SRAV    = 6'h07;
	localparam logic [5:0] FN_JR      = 6'h08;
	localparam logic [5:0] FN_JALR    = 6'h09;
	localparam logic [5:0] FN_SYSCALL = 6'h0c;
	localparam logic [5:0] FN_BREAK   = 6'h0d;
	localparam logic [5:0] FN_ADD     = 6'h20;
	localparam logic [5:0] FN_ADDU    = 6'h21;
	localparam logic [5:0] FN_SUB     = 6'h22;
	localparam logic [5:0] FN_SUBU    = 6'h23;
	localparam logic [5:0] FN_AND     = 6'h24;
	localparam logic [5:0] FN_OR      = 6'h25;
	localparam logic [5:0] FN_XOR     = 6'h26;
	localparam logic [5:0] FN_NOR     = 6'h27;
	localparam logic [5:0] FN_SLT     = 6'h2a;
	localparam logic [5:0] FN_SLTU    = 6'h2b;

	// REGIMM rt field
	localparam reg_addr_t RT_BLTZ   = 5'h00;
	localparam reg_addr_t RT_BGEZ   = 5'h01;
	localparam reg_addr_t RT_BLTZAL = 5'h10;
	localparam reg_addr_t RT_BGEZAL = 5'h11;

	localparam reg_addr_t LINK_REG    = 5'd31;
	localparam word_t     LINK_OFFSET = 32'd8;  // link value is pc + 8

	typedef struct packed {
		alu_op_t     alu_op;
		mem_op_t     mem_op;
		logic        src1_is_sa, src1_is_pc;
		logic        src2_is_imm_s, src2_is_imm_u, src2_is_8;
		logic        waddr_is_31, waddr_is_rt, wren;
		logic        ren1, ren2;
		logic        is_beq, is_bne, is_bgez, is_bgtz;   // bgezal counts as bgez
		logic        is_blez, is_bltz, is_jump_imm, is_jump_reg;
		logic        is_syscall, is_break, is_reserved, is_ov;
		reg_addr_t   rs, rt, rd, sa;
		logic [15:0] imm;
		logic [25:0] j_index;
	} decode_t;

	typedef struct packed {
		word_t     pc, opr1, opr2, offset, rtvalue;
		reg_addr_t waddr;
		logic      wren;
		alu_op_t   alu_op;
		mem_op_t   mem_op;
		logic      nofwd;     // load result not ready for bypass
		exc_t      excs;
		logic      has_exc;
		logic      ov_inst;
	} id_ex_t;

endpackage

//--- operand_select.sv
`timescale 1ns/100ps

module operand_select (
	input  mips_id_pkg::decode_t   dec_i,
	input  mips_id_pkg::word_t     pc_i,
	input  mips_id_pkg::word_t     reg1data_i,
	input  mips_id_pkg::word_t     reg2data_i,
	input  logic                   exc_i,      // fetch side exception
	output mips_id_pkg::id_ex_t    next_o,
	output logic                   ren1_o,
	output logic                   ren2_o,
	output mips_id_pkg::reg_addr_t reg1addr_o,
	output mips_id_pkg::reg_addr_t reg2addr_o
);
	import mips_id_pkg::*;

	word_t sign_ext;
	word_t zero_ext;
	word_t lui_ext;
	exc_t  excs;

	assign sign_ext = {{16{dec_i.imm[15]}}, dec_i.imm};
	assign zero_ext = {16'h0, dec_i.imm};
	assign lui_ext  = {dec_i.imm, 16'h0};
	assign excs     = {dec_i.is_reserved, dec_i.is_break, dec_i.is_syscall, exc_i};

	assign ren1_o     = dec_i.ren1;
	assign ren2_o     = dec_i.ren2;
	assign reg1addr_o = dec_i.rs;
	assign reg2addr_o = dec_i.rt;

	always_comb begin
		next_o.pc   = pc_i;
		next_o.opr1 = dec_i.src1_is_sa ? {27'h0, dec_i.sa} :
		              dec_i.src1_is_pc ? pc_i : reg1data_i;
		next_o.opr2 = dec_i.src2_is_imm_s ? sign_ext :
		              dec_i.src2_is_imm_u ? zero_ext :
		              dec_i.alu_op[11]    ? lui_ext :    // lui
		              dec_i.src2_is_8     ? LINK_OFFSET : reg2data_i;
		next_o.offset  = sign_ext;
		next_o.rtvalue = reg2data_i;   // store data
		next_o.waddr   = dec_i.waddr_is_31 ? LINK_REG :
		                 dec_i.waddr_is_rt ? dec_i.rt : dec_i.rd;
		next_o.wren    = dec_i.wren;
		next_o.alu_op  = dec_i.alu_op;
		next_o.mem_op  = dec_i.mem_op;
		next_o.nofwd   = |dec_i.mem_op[4:0];   // any load
		next_o.excs    = excs;
		next_o.has_exc = |excs;
		next_o.ov_inst = dec_i.is_ov;
	end

endmodule

//--- tb_id_stage.sv
`timescale 1ns/100ps

module tb_id_stage;
	import mips_id_pkg::*;

	typedef struct packed {
		id_ex_t ex;
		logic   ben;
		word_t  bpc;
		logic   isb;
		logic   ren1, ren2;
	} exp_t;

	logic   clk, rst_n_i, id_stall_i, id_flush_i, id_exc_i;
	logic   id_ex_res_as1_i, id_ex_res_as2_i;
	word_t  id_pc_i, id_inst_i, id_reg1data_i, id_reg2data_i;
	word_t  raw_data1_i, raw_data2_i, id_res_from_ex_i;
	logic   id_ren1_o, id_ren2_o, id_branch_en_o, id_is_branch_o;
	reg_addr_t id_reg1addr_o, id_reg2addr_o;
	word_t  id_branch_pc_o;
	id_ex_t id_ex_o;
	exp_t   exp_now;
	id_ex_t exp_q;   // model of the ID/EX register
	logic [31:0] seed_val;

	id_stage i_dut (.*);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	task automatic fail_run(string msg);
		$display("%s", msg);
		$display("=== FAIL ===");
		$fatal(1);
	endtask

	task automatic check_val(string name, logic [199:0] exp, logic [199:0] act);
		if (exp !== act) begin
			fail_run($sformatf("ERROR %s expected %0h actual %0h", name, exp, act));
		end
	endtask

	task automatic wait_rise();
		int n;
		n = 0;
		do begin
			@(clk);
			n++;
		end while (clk !== 1'b1 && n < 4);
		if (clk !== 1'b1) fail_run("timeout waiting for a rising clock edge");
	endtask

	task automatic wait_fall();
		int n;
		n = 0;
		do begin
			@(clk);
			n++;
		end while (clk !== 1'b0 && n < 4);
		if (clk !== 1'b0) fail_run("timeout waiting for a falling clock edge");
	endtask

	// mostly legal encodings, some fully random words
	function automatic word_t gen_inst();
		word_t w;
		logic [31:0] r;
		w = $urandom;
		r = $urandom;
		if (r[20:18] == 3'd0) return w;
		w[31:26] = r[6] ? {2'b10, r[3:0]} : {2'b00, r[3:0]};
		if (w[31:26] == OP_SPECIAL) w[5:0] = r[12] ? {2'b10, r[10:7]} : {2'b00, r[10:7]};
		if (w[31:26] == OP_REGIMM) w[20:16] = {r[13], 3'b000, r[14]};
		if (r[17:15] != 3'd0) begin   // clear fields that must be zero
			if (w[31:26] == OP_SPECIAL) begin
				if (w[5:0] == FN_SLL || w[5:0] == FN_SRL || w[5:0] == FN_SRA) w[25:21] = '0;
				else w[10:6] = '0;
				if (w[5:0] == FN_JR || w[5:0] == FN_JALR) w[20:16] = '0;
				if (w[5:0] == FN_JR) w[15:11] = '0;
			end
			if (w[31:26] == OP_LUI) w[25:21] = '0;
			if (w[31:26] == OP_BLEZ || w[31:26] == OP_BGTZ) w[20:16] = '0;
		end
		return w;
	endfunction

	function automatic exp_t ref_id(word_t inst, word_t pc, word_t r1, word_t r2, logic exc,
		word_t raw1, word_t raw2, word_t exres, logic as1, logic as2);
		exp_t e;
		logic [5:0] op, fn;
		reg_addr_t rs, rt, rd, sa;
		logic [15:0] imm;
		word_t sext, b1, b2, pc4;
		alu_op_t alu;
		mem_op_t mem;
		logic valid, shamt, link, imm_s, imm_u, lui, to_rt, no_wr, load, store, ov, sys, brk;
		logic jimm, jreg, beq, bne, blez, bgtz, bltz, bgez, rr, ialu, rd1, rd2, lz, cond;
		{op, rs, rt, rd, sa, fn} = inst;
		imm = inst[15:0];
		sext = {{16{imm[15]}}, imm};
		alu = '0;
		mem = '0;
		{shamt, link, imm_s, imm_u, lui, to_rt, no_wr, load, store, ov, sys, brk} = '0;
		{jimm, jreg, beq, bne, blez, bgtz, bltz, bgez, rr, ialu, rd1, rd2} = '0;
		valid = 1'b1;
		case (op)
			OP_SPECIAL: begin
				case (fn)
					FN_SLL:  begin alu[8] = 1; shamt = 1; end
					FN_SRL:  begin alu[9] = 1; shamt = 1; end
					FN_SRA:  begin alu[10] = 1; shamt = 1; end
					FN_SLLV: begin alu[8] = 1; rr = 1; end
					FN_SRLV: begin alu[9] = 1; rr = 1; end
					FN_SRAV: begin alu[10] = 1; rr = 1; end
					FN_ADD:  begin alu[0] = 1; ov = 1; rr = 1; end
					FN_ADDU: begin alu[0] = 1; rr = 1; end
					FN_SUB:  begin alu[1] = 1; ov = 1; rr = 1; end
					FN_SUBU: begin alu[1] = 1; rr = 1; end
					FN_AND:  begin alu[4] = 1; rr = 1; end
					FN_OR:   begin alu[6] = 1; rr = 1; end
					FN_XOR:  begin alu[7] = 1; rr = 1; end
					FN_NOR:  begin alu[5] = 1; rr = 1; end
					FN_SLT:  begin alu[2] = 1; rr = 1; end
					FN_SLTU: begin alu[3] = 1; rr = 1; end
					FN_JR:   begin jreg = 1; no_wr = 1; rd1 = 1; valid = sa == 0 && rt == 0 && rd == 0; end
					FN_JALR: begin jreg = 1; link = 1; rd1 = 1; valid = sa == 0 && rt == 0; end
					FN_SYSCALL: begin sys = 1; no_wr = 1; end
					FN_BREAK:   begin brk = 1; no_wr = 1; end
					default: valid = 1'b0;
				endcase
				if (rr) begin
					valid = sa == 0;
					rd1 = 1;
					rd2 = 1;
				end
				if (shamt) begin
					valid = rs == 0;
					rd2 = 1;
				end
			end
			OP_REGIMM: begin
				rd1 = 1;
				case (rt)
					RT_BLTZ:   bltz = 1;
					RT_BGEZ:   bgez = 1;
					RT_BLTZAL: begin bltz = 1; link = 1; end
					RT_BGEZAL: begin bgez = 1; link = 1; end
					default: valid = 1'b0;
				endcase
				no_wr = ~link;
			end
			OP_J:     begin jimm = 1; no_wr = 1; end
			OP_JAL:   begin jimm = 1; link = 1; end
			OP_BEQ:   begin beq = 1; rd1 = 1; rd2 = 1; no_wr = 1; end
			OP_BNE:   begin bne = 1; rd1 = 1; rd2 = 1; no_wr = 1; end
			OP_BLEZ:  begin blez = 1; rd1 = 1; no_wr = 1; valid = rt == 0; end
			OP_BGTZ:  begin bgtz = 1; rd1 = 1; no_wr = 1; valid = rt == 0; end
			OP_ADDI:  begin alu[0] = 1; ov = 1; imm_s = 1; ialu = 1; end
			OP_ADDIU: begin alu[0] = 1; imm_s = 1; ialu = 1; end
			OP_SLTI:  begin alu[2] = 1; imm_s = 1; ialu = 1; end
			OP_SLTIU: begin alu[3] = 1; imm_s = 1; ialu = 1; end
			OP_ANDI:  begin alu[4] = 1; imm_u = 1; ialu = 1; end
			OP_ORI:   begin alu[6] = 1; imm_u = 1; ialu = 1; end
			OP_XORI:  begin alu[7] = 1; imm_u = 1; ialu = 1; end
			OP_LUI:   begin alu[11] = 1; lui = 1; to_rt = 1; valid = rs == 0; end
			OP_LB:    begin mem[0] = 1; load = 1; end
			OP_LBU:   begin mem[1] = 1; load = 1; end
			OP_LH:    begin mem[2] = 1; load = 1; end
			OP_LHU:   begin mem[3] = 1; load = 1; end
			OP_LW:    begin mem[4] = 1; load = 1; end
			OP_SB:    begin mem[5] = 1; store = 1; end
			OP_SH:    begin mem[6] = 1; store = 1; end
			OP_SW:    begin mem[7] = 1; store = 1; end
			default: valid = 1'b0;
		endcase
		if (ialu | load) begin
			to_rt = 1;
			rd1 = 1;
		end
		if (load | store | link) alu[0] = 1;   // address add and link add
		if (load | store) imm_s = 1;
		if (store) begin
			rd1 = 1;
			rd2 = 1;
			no_wr = 1;
		end
		if (!valid) begin
			alu = '0;
			mem = '0;
			{shamt, link, imm_s, imm_u, lui, to_rt, load, ov, sys, brk} = '0;
			{jimm, jreg, beq, bne, blez, bgtz, bltz, bgez, rd1, rd2} = '0;
		end
		e.ex.pc = pc;
		e.ex.opr1 = shamt ? {27'h0, sa} : link ? pc : r1;
		e.ex.opr2 = imm_s ? sext : imm_u ? {16'h0, imm} : lui ? {imm, 16'h0} : link ? 32'd8 : r2;
		e.ex.offset = sext;
		e.ex.rtvalue = r2;
		e.ex.waddr = link ? 5'd31 : to_rt ? rt : rd;
		e.ex.wren = valid & ~no_wr;
		e.ex.alu_op = alu;
		e.ex.mem_op = mem;
		e.ex.nofwd = load;
		e.ex.excs = {~valid, brk, sys, exc};
		e.ex.has_exc = ~valid | brk | sys | exc;
		e.ex.ov_inst = ov;
		e.ren1 = rd1;
		e.ren2 = rd2;
		b1 = as1 ? exres : raw1;
		b2 = as2 ? exres : raw2;
		lz = b1[31];
		pc4 = pc + 32'd4;
		cond = beq | bne | blez | bgtz | bltz | bgez;
		e.ben = (beq && b1 == b2) || (bne && b1 != b2) || (bgez && !lz) || (bltz && lz)
			|| (bgtz && !lz && b1 != 0) || (blez && (lz || b1 == 0)) || jimm || jreg;
		e.bpc = cond ? pc4 + {sext[29:0], 2'b00} : jimm ? {pc4[31:28], inst[25:0], 2'b00} : b1;
		e.isb = cond | jreg;
		return e;
	endfunction

	task automatic drive_random(int i);
		logic [31:0] r;
		r = $urandom;
		rst_n_i = (i % 700) != 699;
		id_stall_i = r[2:0] == 3'd0;
		id_flush_i = r[5:3] == 3'd0;
		id_exc_i = r[9:6] == 4'd0;
		id_ex_res_as1_i = r[10];
		id_ex_res_as2_i = r[11];
		id_inst_i = gen_inst();
		id_pc_i = $urandom & 32'hffff_fffc;   // word aligned
		id_reg1data_i = $urandom;
		id_reg2data_i = $urandom;
		raw_data1_i = r[14:12] == 3'd0 ? 32'd0 : $urandom;
		raw_data2_i = r[16:15] == 2'd0 ? raw_data1_i : $urandom;
		id_res_from_ex_i = r[18:17] == 2'd0 ? raw_data1_i : $urandom;   // equal operands
	endtask

	initial begin
		seed_val = $urandom(32'hb5ed);
		rst_n_i = 1'b0;
		{id_stall_i, id_flush_i, id_exc_i, id_ex_res_as1_i, id_ex_res_as2_i} = '0;
		{id_pc_i, id_inst_i, id_reg1data_i, id_reg2data_i} = '0;
		{raw_data1_i, raw_data2_i, id_res_from_ex_i} = '0;
		repeat (10) wait_fall();
		check_val("reset", 200'(0), 200'(id_ex_o));
		exp_q = '0;
		for (int i = 0; i < 3000; i++) begin
			wait_fall();
			drive_random(i);
			exp_now = ref_id(id_inst_i, id_pc_i, id_reg1data_i, id_reg2data_i, id_exc_i,
				raw_data1_i, raw_data2_i, id_res_from_ex_i, id_ex_res_as1_i, id_ex_res_as2_i);
			#1;
			check_val("branch_en", 200'(exp_now.ben), 200'(id_branch_en_o));
			check_val("branch_pc", 200'(exp_now.bpc), 200'(id_branch_pc_o));
			check_val("is_branch", 200'(exp_now.isb), 200'(id_is_branch_o));
			check_val("ren1", 200'(exp_now.ren1), 200'(id_ren1_o));
			check_val("ren2", 200'(exp_now.ren2), 200'(id_ren2_o));
			check_val("reg1addr", 200'(id_inst_i[25:21]), 200'(id_reg1addr_o));
			check_val("reg2addr", 200'(id_inst_i[20:16]), 200'(id_reg2addr_o));
			wait_rise();
			if (!rst_n_i) exp_q = '0;
			else if (!id_stall_i) exp_q = id_flush_i ? '0 : exp_now.ex;
			#1;
			check_val("id_ex", 200'(exp_q), 200'(id_ex_o));
		end
		$display("=== PASS ===");
		$finish;
	end

endmodule
